/* Makefile */
# Verilator flow for the switch control block

TOP = switch_ctl_tb

.PHONY: all lint sim clean

all: sim

# design on its own, then design with testbench
lint:
	verilator --lint-only --top-module switch_ctl_top \
		logic/switch_ctl_pkg.sv logic/spi_reg_slave.sv logic/control_regs.sv \
		logic/spi_route.sv logic/output_select.sv logic/switch_ctl_top.sv
	verilator --lint-only --timing -f build.f --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+testbench
logic/switch_ctl_pkg.sv
logic/spi_reg_slave.sv
logic/control_regs.sv
logic/spi_route.sv
logic/output_select.sv
logic/switch_ctl_top.sv
testbench/switch_ctl_tb.sv

/* logic/control_regs.sv */
// control register bank
// holds the chain enable, output mode and direct conditioning value,
// writes take effect the cycle after wr_valid, reads are combinational
`timescale 1ns/1ps

module control_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr_valid,
  input  switch_ctl_pkg::reg_addr_t     wr_addr,
  input  switch_ctl_pkg::reg_word_t     wr_data,
  input  switch_ctl_pkg::reg_addr_t     rd_addr,
  output switch_ctl_pkg::reg_word_t     rd_data,
  output logic                          chain_en,
  output switch_ctl_pkg::output_mode_t  mode,
  output switch_ctl_pkg::conditioning_t direct
);

  // only the used bits of each register are stored
  logic                          spi_mux_q;
  switch_ctl_pkg::output_mode_t  mode_q;
  switch_ctl_pkg::conditioning_t direct_q;

  //////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      spi_mux_q <= 1'b0;
      mode_q    <= switch_ctl_pkg::MODE_ZERO;
      direct_q  <= '0;
    end
    else if (wr_valid)
    begin
      case (wr_addr)
        // bit 0 enables the 4094 chain
        switch_ctl_pkg::ADDR_SPI_MUX:
          spi_mux_q <= wr_data[0];
        switch_ctl_pkg::ADDR_MODE:
          mode_q <= switch_ctl_pkg::output_mode_t'(wr_data[1:0]);
        switch_ctl_pkg::ADDR_DIRECT:
          direct_q <= wr_data[switch_ctl_pkg::COND_BITS-1:0];
        default:
        begin
          // writes to unmapped addresses are dropped
          spi_mux_q <= spi_mux_q;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side, zero extended, unmapped reads zero

  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      switch_ctl_pkg::ADDR_SPI_MUX:
        rd_data[0] = spi_mux_q;
      switch_ctl_pkg::ADDR_MODE:
        rd_data[1:0] = mode_q;
      switch_ctl_pkg::ADDR_DIRECT:
        rd_data[switch_ctl_pkg::COND_BITS-1:0] = direct_q;
      default:
        rd_data = '0;
    endcase
  end

  assign chain_en = spi_mux_q;
  assign mode     = mode_q;
  assign direct   = direct_q;

endmodule

/* logic/output_select.sv */
// conditioning output selector
// free-running test pattern and a registered four-way choice between
// zeros, ones, the pattern and the direct register value
`timescale 1ns/1ps

module output_select (
  input  logic                          clk,
  input  logic                          reset,
  input  switch_ctl_pkg::output_mode_t  mode,
  input  switch_ctl_pkg::conditioning_t direct,
  output switch_ctl_pkg::conditioning_t cond
);

  switch_ctl_pkg::conditioning_t pattern_q;
  switch_ctl_pkg::conditioning_t cond_q;

  //////////////////////////////////////////////////////////////////////
  // test pattern

  // counts every clk, wraps at 2^29
  always_ff @(posedge clk)
  begin
    if (reset)
      pattern_q <= '0;
    else
      pattern_q <= pattern_q + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // mode select

  // registered so the pins never glitch on a mode change,
  // pins follow mode or direct one clk later
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cond_q <= '0;
    end
    else
    begin
      case (mode)
        switch_ctl_pkg::MODE_ZERO:
          cond_q <= '0;
        switch_ctl_pkg::MODE_ONES:
          cond_q <= '1;
        switch_ctl_pkg::MODE_PATTERN:
          cond_q <= pattern_q;
        switch_ctl_pkg::MODE_DIRECT:
          cond_q <= direct;
        default:
          cond_q <= '0;
      endcase
    end
  end

  assign cond = cond_q;

endmodule

/* logic/spi_reg_slave.sv */
// oversampled SPI register slave
// decodes 40 bit frames (header byte plus 32 data bits) into register
// writes and shifts the addressed register out on miso for reads
`timescale 1ns/1ps

module spi_reg_slave (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       spi_clk,
  input  logic                       spi_cs_n,
  input  logic                       spi_mosi,
  input  switch_ctl_pkg::reg_word_t  rd_data,
  output logic                       miso,
  output logic                       wr_valid,
  output switch_ctl_pkg::reg_addr_t  wr_addr,
  output switch_ctl_pkg::reg_word_t  wr_data,
  output switch_ctl_pkg::reg_addr_t  rd_addr
);

  // bit counter wide enough to see a frame longer than 40 bits
  localparam int CNT_W = $clog2(switch_ctl_pkg::FRAME_BITS + 1);
  localparam logic [CNT_W-1:0] CNT_FRAME    = CNT_W'(switch_ctl_pkg::FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_HDR_LAST = CNT_W'(switch_ctl_pkg::HEADER_BITS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_DATA
  } state_t;

  state_t                     state_q;
  logic [1:0]                 clk_sync_q;
  logic [1:0]                 cs_sync_q;
  logic [1:0]                 mosi_sync_q;
  logic                       clk_d_q;
  logic                       cs_d_q;
  logic                       clk_rise;
  logic                       clk_fall;
  logic                       cs_start;
  logic                       cs_end;
  logic [CNT_W-1:0]           bit_cnt_q;
  logic                       hdr_done_q;
  logic [switch_ctl_pkg::HEADER_BITS-1:0] hdr_q;
  switch_ctl_pkg::reg_word_t  data_q;
  switch_ctl_pkg::reg_word_t  rd_shift_q;
  logic                       is_write;

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers and edge detect

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_sync_q  <= '0;
      cs_sync_q   <= 2'b11;
      mosi_sync_q <= '0;
      clk_d_q     <= 1'b0;
      cs_d_q      <= 1'b1;
    end
    else
    begin
      clk_sync_q  <= {clk_sync_q[0], spi_clk};
      cs_sync_q   <= {cs_sync_q[0], spi_cs_n};
      mosi_sync_q <= {mosi_sync_q[0], spi_mosi};
      clk_d_q     <= clk_sync_q[1];
      cs_d_q      <= cs_sync_q[1];
    end
  end

  assign clk_rise = clk_sync_q[1] & ~clk_d_q;
  assign clk_fall = ~clk_sync_q[1] & clk_d_q;
  // chip select is active low
  assign cs_start = ~cs_sync_q[1] & cs_d_q;
  assign cs_end   = cs_sync_q[1] & ~cs_d_q;

  // header msb is the write flag
  assign is_write = hdr_q[switch_ctl_pkg::HEADER_BITS-1];

  //////////////////////////////////////////////////////////////////////
  // frame FSM, bit count and commit

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q    <= ST_IDLE;
      bit_cnt_q  <= '0;
      hdr_done_q <= 1'b0;
      wr_valid   <= 1'b0;
      miso       <= 1'b0;
    end
    else
    begin
      wr_valid   <= 1'b0;
      hdr_done_q <= 1'b0;
      if (cs_end)
      begin
        state_q <= ST_IDLE;
        miso    <= 1'b0;
        // only an exact 40 bit write frame commits
        if (state_q == ST_DATA && bit_cnt_q == CNT_FRAME && is_write)
          wr_valid <= 1'b1;
      end
      else if (cs_start)
      begin
        state_q   <= ST_HEADER;
        bit_cnt_q <= '0;
        miso      <= 1'b0;
      end
      else
      begin
        case (state_q)
          ST_HEADER:
          begin
            if (clk_rise)
            begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == CNT_HDR_LAST)
              begin
                state_q    <= ST_DATA;
                hdr_done_q <= 1'b1;
              end
            end
          end
          ST_DATA:
          begin
            // saturate so an overlong frame never wraps back to 40
            if (clk_rise && bit_cnt_q != '1)
              bit_cnt_q <= bit_cnt_q + 1'b1;
            if (clk_fall)
              miso <= rd_shift_q[switch_ctl_pkg::WORD_BITS-1];
          end
          default:
          begin
            bit_cnt_q <= bit_cnt_q;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // header, write data and read shifters

  always_ff @(posedge clk)
  begin
    if (state_q == ST_HEADER && clk_rise && !cs_end)
      hdr_q <= {hdr_q[switch_ctl_pkg::HEADER_BITS-2:0], mosi_sync_q[1]};
    if (state_q == ST_DATA && clk_rise && !cs_end)
      data_q <= {data_q[switch_ctl_pkg::WORD_BITS-2:0], mosi_sync_q[1]};
    // rd_data answers the header address one cycle after it completes
    if (hdr_done_q)
      rd_shift_q <= is_write ? '0 : rd_data;
    else if (state_q == ST_DATA && clk_fall)
      rd_shift_q <= {rd_shift_q[switch_ctl_pkg::WORD_BITS-2:0], 1'b0};
  end

  // address and data hold steady from frame end until the next frame
  assign rd_addr = hdr_q[switch_ctl_pkg::ADDR_BITS-1:0];
  assign wr_addr = hdr_q[switch_ctl_pkg::ADDR_BITS-1:0];
  assign wr_data = data_q;

endmodule

/* logic/spi_route.sv */
// SPI routing to the 4094 chain
// passes clock and data to the chain while its chip select is low and
// the chain is enabled, and picks the source of the MISO pin
`timescale 1ns/1ps

module spi_route #(
  parameter bit STROBE_ACTIVE_HIGH = 1'b1
) (
  input  logic spi_clk,
  input  logic spi_cs2_n,
  input  logic spi_mosi,
  input  logic chain_en,
  input  logic chain_return,
  input  logic slave_miso,
  output logic chain_clk,
  output logic chain_data,
  output logic chain_strobe,
  output logic miso
);

  logic chain_active;

  // second chip select is active low and gated by the mux register
  assign chain_active = ~spi_cs2_n & chain_en;

  //////////////////////////////////////////////////////////////////////
  // chain side

  // clock and data held low while the chain is idle
  assign chain_clk  = chain_active & spi_clk;
  assign chain_data = chain_active & spi_mosi;

  // 4094 strobe follows the chip select at the board polarity
  generate
    if (STROBE_ACTIVE_HIGH)
    begin : g_strobe_high
      assign chain_strobe = chain_active;
    end
    else
    begin : g_strobe_low
      assign chain_strobe = ~chain_active;
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // MISO source

  // chain return line when the chain owns the bus,
  // register slave otherwise
  assign miso = chain_active ? chain_return : slave_miso;

endmodule

/* logic/switch_ctl_pkg.sv */
// switch control shared definitions
// register widths and map, output modes, SPI frame lengths and the
// bit layout of the conditioning vector
package switch_ctl_pkg;

  localparam int WORD_BITS = 32;
  localparam int ADDR_BITS = 7;
  localparam int COND_BITS = 29;

  typedef logic [WORD_BITS-1:0] reg_word_t;
  typedef logic [ADDR_BITS-1:0] reg_addr_t;
  typedef logic [COND_BITS-1:0] conditioning_t;

  // what the conditioning vector carries
  typedef enum logic [1:0] {
    MODE_ZERO    = 2'd0,
    MODE_ONES    = 2'd1,
    MODE_PATTERN = 2'd2,
    MODE_DIRECT  = 2'd3
  } output_mode_t;

  // register map
  localparam reg_addr_t ADDR_SPI_MUX = 7'd1;
  localparam reg_addr_t ADDR_MODE    = 7'd2;
  localparam reg_addr_t ADDR_DIRECT  = 7'd3;

  // header byte then 32 data bits, msb first
  localparam int FRAME_BITS  = 40;
  localparam int HEADER_BITS = 8;

  // conditioning vector layout, group widths and lsb positions
  localparam int MUX_W          = 4;
  localparam int MON_W          = 8;
  localparam int ADC_W          = 4;
  localparam int COND_AZ_LSB    = 0;
  localparam int COND_HI_LSB    = 4;
  localparam int COND_HI2_LSB   = 8;
  localparam int COND_PC_BIT    = 12;
  localparam int COND_LED_BIT   = 13;
  localparam int COND_MON_LSB   = 14;
  localparam int COND_ADC_LSB   = 22;
  localparam int COND_LATCH_BIT = 26;
  localparam int COND_MEAS_BIT  = 27;
  localparam int COND_IRQ_BIT   = 28;

endpackage

/* logic/switch_ctl_top.sv */
// switch control top level
// SPI register slave, register bank, 4094 chain routing and the
// conditioning output selector, with the vector split onto named pins
`timescale 1ns/1ps

module switch_ctl_top #(
  parameter bit STROBE_ACTIVE_HIGH = 1'b1
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             spi_clk,
  input  logic                             spi_cs_n,
  input  logic                             spi_cs2_n,
  input  logic                             spi_mosi,
  input  logic                             chain_return,
  output logic                             spi_miso,
  output logic                             chain_clk,
  output logic                             chain_data,
  output logic                             chain_strobe,
  output logic [switch_ctl_pkg::MUX_W-1:0] az_mux,
  output logic [switch_ctl_pkg::MUX_W-1:0] hi_mux,
  output logic [switch_ctl_pkg::MUX_W-1:0] hi_mux2,
  output logic                             pc_sw,
  output logic                             led,
  output logic [switch_ctl_pkg::MON_W-1:0] monitor,
  output logic [switch_ctl_pkg::ADC_W-1:0] adc_sw,
  output logic                             cmpr_latch,
  output logic                             meas_complete,
  output logic                             spi_interrupt
);

  logic                          wr_valid;
  switch_ctl_pkg::reg_addr_t     wr_addr;
  switch_ctl_pkg::reg_word_t     wr_data;
  switch_ctl_pkg::reg_addr_t     rd_addr;
  switch_ctl_pkg::reg_word_t     rd_data;
  logic                          slave_miso;
  logic                          chain_en;
  switch_ctl_pkg::output_mode_t  mode;
  switch_ctl_pkg::conditioning_t direct;
  switch_ctl_pkg::conditioning_t cond;

  //////////////////////////////////////////////////////////////////////
  // register access

  spi_reg_slave spi_reg_slave_inst (
    .clk      (clk),
    .reset    (reset),
    .spi_clk  (spi_clk),
    .spi_cs_n (spi_cs_n),
    .spi_mosi (spi_mosi),
    .rd_data  (rd_data),
    .miso     (slave_miso),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr)
  );

  control_regs control_regs_inst (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .chain_en (chain_en),
    .mode     (mode),
    .direct   (direct)
  );

  // raw pins go straight to the chain, no synchronizers on this path
  spi_route #(
    .STROBE_ACTIVE_HIGH (STROBE_ACTIVE_HIGH)
  ) spi_route_inst (
    .spi_clk      (spi_clk),
    .spi_cs2_n    (spi_cs2_n),
    .spi_mosi     (spi_mosi),
    .chain_en     (chain_en),
    .chain_return (chain_return),
    .slave_miso   (slave_miso),
    .chain_clk    (chain_clk),
    .chain_data   (chain_data),
    .chain_strobe (chain_strobe),
    .miso         (spi_miso)
  );

  //////////////////////////////////////////////////////////////////////
  // conditioning outputs

  output_select output_select_inst (
    .clk    (clk),
    .reset  (reset),
    .mode   (mode),
    .direct (direct),
    .cond   (cond)
  );

  // mux groups are {en, a2, a1, a0}
  assign az_mux        = cond[switch_ctl_pkg::COND_AZ_LSB +: switch_ctl_pkg::MUX_W];
  assign hi_mux        = cond[switch_ctl_pkg::COND_HI_LSB +: switch_ctl_pkg::MUX_W];
  assign hi_mux2       = cond[switch_ctl_pkg::COND_HI2_LSB +: switch_ctl_pkg::MUX_W];
  assign pc_sw         = cond[switch_ctl_pkg::COND_PC_BIT];
  assign led           = cond[switch_ctl_pkg::COND_LED_BIT];
  assign monitor       = cond[switch_ctl_pkg::COND_MON_LSB +: switch_ctl_pkg::MON_W];
  assign adc_sw        = cond[switch_ctl_pkg::COND_ADC_LSB +: switch_ctl_pkg::ADC_W];
  assign cmpr_latch    = cond[switch_ctl_pkg::COND_LATCH_BIT];
  assign meas_complete = cond[switch_ctl_pkg::COND_MEAS_BIT];
  assign spi_interrupt = cond[switch_ctl_pkg::COND_IRQ_BIT];

endmodule

/* testbench/spi_master_tasks.svh */
// SPI master tasks for the switch control testbench
// drives 40 bit register frames, mode 0, and supplies xorshift numbers
`ifndef SPI_MASTER_TASKS_SVH
`define SPI_MASTER_TASKS_SVH

// clk cycles per SPI clock level
localparam int HALF_PERIOD = 5;

// 32 bit xorshift with 13/17/5 shifts
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

task automatic next_rand(output switch_ctl_pkg::reg_word_t value);
  rng_state = xorshift32(rng_state);
  value     = rng_state;
endtask

task automatic spi_half_period();
  repeat (HALF_PERIOD) @(negedge clk);
endtask

// header byte then 32 data bits, msb first
// mosi changes with the falling SPI clock, miso is taken just before each
// rising edge of the data phase
task automatic spi_frame(input logic [7:0] header,
                         input switch_ctl_pkg::reg_word_t wdata,
                         output switch_ctl_pkg::reg_word_t rdata);
  logic [39:0] frame;
  int          i;
  frame = {header, wdata};
  rdata = '0;
  @(negedge clk);
  spi_cs_n = 1'b0;
  spi_half_period();
  for (i = 39; i >= 0; i--)
  begin
    spi_mosi = frame[i];
    spi_half_period();
    if (i < 32)
      rdata = {rdata[30:0], spi_miso};
    spi_clk = 1'b1;
    spi_half_period();
    spi_clk = 1'b0;
  end
  spi_half_period();
  spi_cs_n = 1'b1;
  spi_mosi = 1'b0;
  // room for the commit before the next frame
  spi_half_period();
  spi_half_period();
endtask

task automatic reg_write(input switch_ctl_pkg::reg_addr_t addr,
                         input switch_ctl_pkg::reg_word_t data);
  switch_ctl_pkg::reg_word_t unused;
  spi_frame({1'b1, addr}, data, unused);
endtask

task automatic reg_read(input switch_ctl_pkg::reg_addr_t addr,
                        output switch_ctl_pkg::reg_word_t data);
  spi_frame({1'b0, addr}, '0, data);
endtask

`endif

/* testbench/switch_ctl_tb.sv */
// switch control testbench
// writes registers over SPI, checks the conditioning pins against a
// reference model every clk and checks the 4094 chain routing
`timescale 1ns/1ps

module switch_ctl_tb;

  localparam logic [31:0] RNG_SEED = 32'h153a0da9;
  // clk cycles allowed for a register write to reach the pins
  localparam int POLL_LIMIT = 100;

  logic clk = 1'b0;
  logic reset;
  logic spi_clk;
  logic spi_cs_n;
  logic spi_cs2_n;
  logic spi_mosi;
  logic chain_return;
  logic spi_miso;
  logic chain_clk;
  logic chain_data;
  logic chain_strobe;
  logic [3:0] az_mux;
  logic [3:0] hi_mux;
  logic [3:0] hi_mux2;
  logic pc_sw;
  logic led;
  logic [7:0] monitor;
  logic [3:0] adc_sw;
  logic cmpr_latch;
  logic meas_complete;
  logic spi_interrupt;

  switch_ctl_pkg::conditioning_t cond_pins;
  switch_ctl_pkg::conditioning_t prev_cond = '0;
  switch_ctl_pkg::output_mode_t  model_mode;
  switch_ctl_pkg::conditioning_t model_direct;
  logic                          track_en;
  logic [31:0]                   rng_state;

  switch_ctl_top #(
    .STROBE_ACTIVE_HIGH (1'b1)
  ) switch_ctl_top_inst (
    .clk           (clk),
    .reset         (reset),
    .spi_clk       (spi_clk),
    .spi_cs_n      (spi_cs_n),
    .spi_cs2_n     (spi_cs2_n),
    .spi_mosi      (spi_mosi),
    .chain_return  (chain_return),
    .spi_miso      (spi_miso),
    .chain_clk     (chain_clk),
    .chain_data    (chain_data),
    .chain_strobe  (chain_strobe),
    .az_mux        (az_mux),
    .hi_mux        (hi_mux),
    .hi_mux2       (hi_mux2),
    .pc_sw         (pc_sw),
    .led           (led),
    .monitor       (monitor),
    .adc_sw        (adc_sw),
    .cmpr_latch    (cmpr_latch),
    .meas_complete (meas_complete),
    .spi_interrupt (spi_interrupt)
  );

  // pins put back together in layout order from bit 28 down to bit 0
  assign cond_pins = {spi_interrupt, meas_complete, cmpr_latch, adc_sw, monitor,
                      led, pc_sw, hi_mux2, hi_mux, az_mux};

  always #2 clk = ~clk;

  `include "spi_master_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // checks and reference model

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_cond(input switch_ctl_pkg::conditioning_t got,
                            input switch_ctl_pkg::conditioning_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_word(input switch_ctl_pkg::reg_word_t got,
                            input switch_ctl_pkg::reg_word_t exp, input string what);
    if (got !== exp)
      fail_now($sformatf("ERROR @%0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_now($sformatf("ERROR @%0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  // pattern mode has no absolute value, so it steps from the last sample
  function automatic switch_ctl_pkg::conditioning_t ref_cond(
    input switch_ctl_pkg::output_mode_t mode, input switch_ctl_pkg::conditioning_t direct,
    input switch_ctl_pkg::conditioning_t prev);
    case (mode)
      switch_ctl_pkg::MODE_ZERO:    return '0;
      switch_ctl_pkg::MODE_ONES:    return '1;
      switch_ctl_pkg::MODE_PATTERN: return prev + 1'b1;
      default:                      return direct;
    endcase
  endfunction

  // compare process samples the pins at the falling edge where they are stable
  always @(negedge clk)
  begin
    if (track_en)
      check_cond(cond_pins, ref_cond(model_mode, model_direct, prev_cond), "conditioning pins");
    prev_cond <= cond_pins;
  end

  //////////////////////////////////////////////////////////////////////
  // scenario helpers

  task automatic wait_cond_match(input switch_ctl_pkg::output_mode_t mode,
                                 input switch_ctl_pkg::conditioning_t direct);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (cond_pins !== ref_cond(mode, direct, prev_cond))
    begin
      cycles++;
      if (cycles > POLL_LIMIT)
        fail_now("timeout, the conditioning pins never reached the expected value");
      @(negedge clk);
    end
  endtask

  // wait for the new setting, then let the compare process track it
  task automatic expect_cond(input switch_ctl_pkg::output_mode_t mode,
                             input switch_ctl_pkg::conditioning_t direct, input int cycles);
    model_mode   <= mode;
    model_direct <= direct;
    wait_cond_match(mode, direct);
    track_en <= 1'b1;
    repeat (cycles) @(negedge clk);
    track_en <= 1'b0;
  endtask

  task automatic write_mode(input switch_ctl_pkg::output_mode_t mode);
    reg_write(switch_ctl_pkg::ADDR_MODE, {30'b0, mode});
  endtask

  // drive random SPI levels with the chain selected and check the route
  task automatic route_check(input logic enabled, input int steps);
    switch_ctl_pkg::reg_word_t w;
    int                        i;
    spi_cs2_n = 1'b0;
    for (i = 0; i < steps; i++)
    begin
      next_rand(w);
      spi_clk      = w[0];
      spi_mosi     = w[1];
      chain_return = w[2];
      // outputs checked one clk later before the next levels go out
      @(negedge clk);
      check_bit(chain_clk, enabled & w[0], "chain_clk");
      check_bit(chain_data, enabled & w[1], "chain_data");
      check_bit(chain_strobe, enabled, "chain_strobe");
      // idle slave keeps miso low outside a frame
      check_bit(spi_miso, enabled ? w[2] : 1'b0, "spi_miso");
    end
    spi_cs2_n    = 1'b1;
    spi_clk      = 1'b0;
    spi_mosi     = 1'b0;
    chain_return = 1'b0;
    @(negedge clk);
    check_bit(chain_strobe, 1'b0, "chain_strobe after deselect");
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus

  initial
  begin
    switch_ctl_pkg::reg_word_t w;
    switch_ctl_pkg::reg_word_t r;
    int                        k;
    reset        = 1'b1;
    spi_clk      = 1'b0;
    spi_cs_n     = 1'b1;
    spi_cs2_n    = 1'b1;
    spi_mosi     = 1'b0;
    chain_return = 1'b0;
    track_en     = 1'b0;
    model_mode   = switch_ctl_pkg::MODE_ZERO;
    model_direct = '0;
    rng_state    = RNG_SEED;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // everything low and idle out of reset
    @(negedge clk);
    check_cond(cond_pins, '0, "pins after reset");
    check_bit(spi_miso, 1'b0, "spi_miso after reset");
    check_bit(chain_clk, 1'b0, "chain_clk after reset");
    check_bit(chain_data, 1'b0, "chain_data after reset");
    check_bit(chain_strobe, 1'b0, "chain_strobe after reset");

    // direct values onto the pins
    next_rand(w);
    reg_write(switch_ctl_pkg::ADDR_DIRECT, w);
    write_mode(switch_ctl_pkg::MODE_DIRECT);
    expect_cond(switch_ctl_pkg::MODE_DIRECT, w[28:0], 10);
    for (k = 0; k < 4; k++)
    begin
      next_rand(w);
      reg_write(switch_ctl_pkg::ADDR_DIRECT, w);
      expect_cond(switch_ctl_pkg::MODE_DIRECT, w[28:0], 10);
    end

    // all ones and then back to all zeros
    write_mode(switch_ctl_pkg::MODE_ONES);
    expect_cond(switch_ctl_pkg::MODE_ONES, w[28:0], 10);
    write_mode(switch_ctl_pkg::MODE_ZERO);
    expect_cond(switch_ctl_pkg::MODE_ZERO, w[28:0], 10);

    // counter steps by one every clk
    write_mode(switch_ctl_pkg::MODE_PATTERN);
    expect_cond(switch_ctl_pkg::MODE_PATTERN, w[28:0], 64);

    // read-back is zero extended
    for (k = 0; k < 3; k++)
    begin
      next_rand(w);
      reg_write(switch_ctl_pkg::ADDR_SPI_MUX, w);
      reg_read(switch_ctl_pkg::ADDR_SPI_MUX, r);
      check_word(r, {31'b0, w[0]}, "spi_mux read-back");
      next_rand(w);
      reg_write(switch_ctl_pkg::ADDR_MODE, w);
      reg_read(switch_ctl_pkg::ADDR_MODE, r);
      check_word(r, {30'b0, w[1:0]}, "mode read-back");
      next_rand(w);
      reg_write(switch_ctl_pkg::ADDR_DIRECT, w);
      reg_read(switch_ctl_pkg::ADDR_DIRECT, r);
      check_word(r, {3'b0, w[28:0]}, "direct read-back");
    end
    next_rand(w);
    reg_write(7'd5, w);
    reg_read(7'd5, r);
    check_word(r, '0, "unmapped read-back");

    // 4094 chain routing with the chain enabled and then disabled
    reg_write(switch_ctl_pkg::ADDR_SPI_MUX, 32'd1);
    route_check(1'b1, 24);
    reg_write(switch_ctl_pkg::ADDR_SPI_MUX, 32'd0);
    route_check(1'b0, 24);

    $display("TEST OK");
    $finish;
  end

endmodule
